// ==== verilog/mmu_pkg.sv ====
package mmu_pkg;

    parameter int TLB_ENTRIES = 8;

    // top three address bits
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;
    localparam logic [2:0] SEG_KSEG2 = 3'b110;
    localparam logic [2:0] SEG_KSEG3 = 3'b111;

    localparam logic [3:0] WR_DISABLE = 4'b0000;

    localparam logic [4:0] CP0_INDEX   = 5'd0;
    localparam logic [4:0] CP0_ENTRYLO = 5'd2;
    localparam logic [4:0] CP0_ENTRYHI = 5'd10;
    localparam logic [4:0] CP0_STATUS  = 5'd12;
    localparam logic [4:0] CP0_CONFIG  = 5'd16;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] low;
    } va_seg_t;

    typedef struct packed {
        logic [19:0] vpn;
        logic [11:0] offset;
    } va_page_t;

    // same virtual address, segment or page view
    typedef union packed {
        va_seg_t  segment;
        va_page_t page;
    } va_t;

    typedef struct packed {
        logic        present;
        logic [19:0] vpn;
        logic [19:0] pfn;
        logic        c;                 // cacheable
        logic        d;                 // writable
        logic        v;                 // valid
        logic        spare;
    } tlb_entry_t;

    typedef struct packed {
        logic        rdy;
        logic [19:0] pfn;
        logic        cat;
        logic        tlbr;
        logic        tlbi;
        logic        tlbm;
    } tlb_result_t;

    typedef struct packed {
        logic        erl;
        logic        k0;
        logic        k23;
        logic        ku;
        logic [3:0]  index;
        logic [19:0] entryhi_vpn;
        logic [19:0] pfn;
        logic        c;
        logic        d;
        logic        v;
    } cp0_view_t;

    // kuseg, kseg2 and kseg3 go through the TLB
    function automatic logic is_mapped(input logic [2:0] seg);
        return !seg[2] || seg == SEG_KSEG2 || seg == SEG_KSEG3;
    endfunction

endpackage

// ==== verilog/cp0_mmu_regs.sv ====
`timescale 1ns/1ns

module cp0_mmu_regs import mmu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cp0_we,
    input  logic [4:0]  cp0_addr,
    input  logic [31:0] cp0_wdata,
    output logic [31:0] cp0_rdata,
    output cp0_view_t   cp0
);

    // implemented bits per register
    localparam logic [31:0] INDEX_MASK   = 32'h0000_000f;
    localparam logic [31:0] ENTRYLO_MASK = 32'h03ff_ffce; // pfn, c, d, v
    localparam logic [31:0] ENTRYHI_MASK = 32'hffff_f000; // vpn
    localparam logic [31:0] STATUS_MASK  = 32'h0000_0004; // erl only
    localparam logic [31:0] CONFIG_MASK  = 32'h0000_0007; // ku, k23, k0

    logic [31:0] index_r;
    logic [31:0] entrylo_r;
    logic [31:0] entryhi_r;
    logic [31:0] status_r;
    logic [31:0] config_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            index_r   <= 32'h0;
            entrylo_r <= 32'h0;
            entryhi_r <= 32'h0;
            status_r  <= 32'h0;
            config_r  <= 32'h0;
        end else if (cp0_we) begin
            case (cp0_addr)
                CP0_INDEX:   index_r   <= cp0_wdata & INDEX_MASK;
                CP0_ENTRYLO: entrylo_r <= cp0_wdata & ENTRYLO_MASK;
                CP0_ENTRYHI: entryhi_r <= cp0_wdata & ENTRYHI_MASK;
                CP0_STATUS:  status_r  <= cp0_wdata & STATUS_MASK;
                CP0_CONFIG:  config_r  <= cp0_wdata & CONFIG_MASK;
                default: ;              // unknown number, dropped
            endcase
        end
    end

    always_comb begin
        case (cp0_addr)
            CP0_INDEX:   cp0_rdata = index_r;
            CP0_ENTRYLO: cp0_rdata = entrylo_r;
            CP0_ENTRYHI: cp0_rdata = entryhi_r;
            CP0_STATUS:  cp0_rdata = status_r;
            CP0_CONFIG:  cp0_rdata = config_r;
            default:     cp0_rdata = 32'h0;
        endcase
    end

    assign cp0.erl         = status_r[2];
    assign cp0.k0          = config_r[0];
    assign cp0.k23         = config_r[1];
    assign cp0.ku          = config_r[2];
    assign cp0.index       = index_r[3:0];
    assign cp0.entryhi_vpn = entryhi_r[31:12];
    assign cp0.pfn         = entrylo_r[25:6];
    assign cp0.c           = entrylo_r[3];  // low bit of the C field
    assign cp0.d           = entrylo_r[2];
    assign cp0.v           = entrylo_r[1];

endmodule

// ==== verilog/tlb_lookup.sv ====
`timescale 1ns/1ns

module tlb_lookup import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = mmu_pkg::TLB_ENTRIES
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        tlb_en,
    input  va_t         tlb_vaddr,
    input  logic        tlb_refs,
    input  logic        tlbwi,
    input  cp0_view_t   cp0,
    output tlb_result_t result
);

    localparam int IW = $clog2(TLB_ENTRIES);

    tlb_entry_t  ents [TLB_ENTRIES];

    logic          busy;            // search walking the entries
    logic          done;            // result latched for cur_vpn/cur_refs
    logic [IW-1:0] ptr;
    logic [19:0]   cur_vpn;
    logic          cur_refs;

    logic [19:0]   res_pfn;
    logic          res_cat;
    logic          res_tlbr;
    logic          res_tlbi;
    logic          res_tlbm;

    logic          same_req;
    logic          hit;
    logic          last;
    tlb_entry_t    cur_ent;
    logic [IW-1:0] wr_idx;

    assign wr_idx   = cp0.index[IW-1:0];
    assign cur_ent  = ents[ptr];
    assign hit      = cur_ent.present && cur_ent.vpn == cur_vpn;
    assign last     = ptr == IW'(TLB_ENTRIES - 1);
    assign same_req = tlb_en && tlb_vaddr.page.vpn == cur_vpn && tlb_refs == cur_refs;

    // entry storage, written by tlbwi
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                ents[i].present <= 1'b0;
            end
        end else if (tlbwi) begin
            ents[wr_idx] <= '{present: 1'b1,
                              vpn:     cp0.entryhi_vpn,
                              pfn:     cp0.pfn,
                              c:       cp0.c,
                              d:       cp0.d,
                              v:       cp0.v,
                              spare:   1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            ptr      <= '0;
            cur_vpn  <= '0;
            cur_refs <= 1'b0;
            res_tlbr <= 1'b0;
            res_tlbi <= 1'b0;
            res_tlbm <= 1'b0;
        end else if (tlbwi || !tlb_en) begin
            busy <= 1'b0;               // entries changed or request gone
            done <= 1'b0;
        end else if (!same_req || !(busy || done)) begin
            busy     <= 1'b1;           // (re)start at entry 0
            done     <= 1'b0;
            ptr      <= '0;
            cur_vpn  <= tlb_vaddr.page.vpn;
            cur_refs <= tlb_refs;
        end else if (busy) begin
            if (hit || last) begin
                busy     <= 1'b0;
                done     <= 1'b1;
                res_tlbr <= !hit;
                res_tlbi <= hit && !cur_ent.v;
                res_tlbm <= hit && cur_ent.v && cur_refs && !cur_ent.d;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    // frame and cacheability of the matching entry
    always_ff @(posedge clk) begin
        if (busy && hit) begin
            res_pfn <= cur_ent.pfn;
            res_cat <= cur_ent.c;
        end
    end

    // stale result never shown for a changed request
    assign result.rdy  = done && same_req;
    assign result.pfn  = res_pfn;
    assign result.cat  = res_cat;
    assign result.tlbr = res_tlbr;
    assign result.tlbi = res_tlbi;
    assign result.tlbm = res_tlbm;

endmodule

// ==== verilog/mmu_translate.sv ====
`timescale 1ns/1ns

module mmu_translate import mmu_pkg::*; (
    input  logic        en,
    input  logic [3:0]  wen,
    input  va_t         vaddr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,

    output logic        bus_en,
    output logic [3:0]  bus_wen,
    output logic [31:0] bus_paddr,
    output logic [31:0] bus_wdata,
    input  logic [31:0] bus_rdata,
    input  logic        bus_streq,
    output logic        bus_cached,

    output logic        tlb_en,
    output va_t         tlb_vaddr,
    output logic        tlb_refs,
    input  tlb_result_t tlb,

    input  logic        exc_flag,
    input  cp0_view_t   cp0,
    output logic        exc_tlbr,
    output logic        exc_tlbi,
    output logic        exc_tlbm,

    output logic        stallreq
);

    logic tlb_streq;                    // waiting on the TLB search
    logic mapped;
    logic [31:0] direct_paddr;          // top three bits cleared

    assign mapped       = is_mapped(vaddr.segment.seg);
    assign direct_paddr = {3'b000, vaddr.segment.low};

    assign bus_wen   = en ? wen : WR_DISABLE;
    assign bus_wdata = wdata;
    assign rdata     = en ? bus_rdata : 32'h0;
    assign stallreq  = bus_streq || tlb_streq;

    always_comb begin
        tlb_en     = 1'b0;
        tlb_vaddr  = '0;
        tlb_refs   = 1'b0;
        tlb_streq  = 1'b0;
        bus_en     = 1'b0;
        bus_paddr  = 32'h0;
        bus_cached = 1'b0;
        exc_tlbr   = 1'b0;
        exc_tlbi   = 1'b0;
        exc_tlbm   = 1'b0;

        if (!mapped) begin
            // kseg0 cached per Config.K0, kseg1 never cached
            bus_paddr  = direct_paddr;
            bus_en     = en && !exc_flag;
            bus_cached = (vaddr.segment.seg == SEG_KSEG0) && cp0.k0;
        end else if (cp0.erl) begin
            bus_paddr  = direct_paddr;  // error level, bypass TLB
            bus_en     = en && !exc_flag;
            bus_cached = 1'b0;
        end else if (en) begin
            tlb_en     = 1'b1;
            tlb_vaddr  = vaddr;
            tlb_refs   = wen != WR_DISABLE;
            tlb_streq  = !tlb.rdy;
            bus_paddr  = {tlb.pfn, vaddr.page.offset};
            bus_en     = tlb.rdy && !exc_flag;
            bus_cached = tlb.cat;
            exc_tlbr   = tlb.tlbr && tlb.rdy;
            exc_tlbi   = tlb.tlbi && tlb.rdy;
            exc_tlbm   = tlb.tlbm && tlb.rdy;
        end
    end

endmodule

// ==== verilog/mmu_top.sv ====
`timescale 1ns/1ns

module mmu_top import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = mmu_pkg::TLB_ENTRIES
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        en,
    input  logic [3:0]  wen,
    input  logic [31:0] vaddr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    input  logic        exc_flag,

    output logic        bus_en,
    output logic [3:0]  bus_wen,
    output logic [31:0] bus_paddr,
    output logic [31:0] bus_wdata,
    input  logic [31:0] bus_rdata,
    input  logic        bus_streq,
    output logic        bus_cached,

    output logic        exc_tlbr,
    output logic        exc_tlbi,
    output logic        exc_tlbm,
    output logic        stallreq,

    input  logic        cp0_we,
    input  logic [4:0]  cp0_addr,
    input  logic [31:0] cp0_wdata,
    output logic [31:0] cp0_rdata,
    input  logic        tlbwi
);

    cp0_view_t   cp0;
    logic        tlb_en;
    va_t         tlb_vaddr;
    logic        tlb_refs;
    tlb_result_t tlb_res;

    cp0_mmu_regs cp0_mmu_regs_i (
        .clk       (clk),
        .rst       (rst),
        .cp0_we    (cp0_we),
        .cp0_addr  (cp0_addr),
        .cp0_wdata (cp0_wdata),
        .cp0_rdata (cp0_rdata),
        .cp0       (cp0)
    );

    tlb_lookup #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) tlb_lookup_i (
        .clk       (clk),
        .rst       (rst),
        .tlb_en    (tlb_en),
        .tlb_vaddr (tlb_vaddr),
        .tlb_refs  (tlb_refs),
        .tlbwi     (tlbwi),
        .cp0       (cp0),
        .result    (tlb_res)
    );

    mmu_translate mmu_translate_i (
        .en         (en),
        .wen        (wen),
        .vaddr      (vaddr),
        .wdata      (wdata),
        .rdata      (rdata),
        .bus_en     (bus_en),
        .bus_wen    (bus_wen),
        .bus_paddr  (bus_paddr),
        .bus_wdata  (bus_wdata),
        .bus_rdata  (bus_rdata),
        .bus_streq  (bus_streq),
        .bus_cached (bus_cached),
        .tlb_en     (tlb_en),
        .tlb_vaddr  (tlb_vaddr),
        .tlb_refs   (tlb_refs),
        .tlb        (tlb_res),
        .exc_flag   (exc_flag),
        .cp0        (cp0),
        .exc_tlbr   (exc_tlbr),
        .exc_tlbi   (exc_tlbi),
        .exc_tlbm   (exc_tlbm),
        .stallreq   (stallreq)
    );

endmodule

// ==== tb/mmu_top_chk.sv ====
`timescale 1ns/1ns

module mmu_top_chk import mmu_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        exc_flag,
    input logic        bus_en,
    input logic        stallreq,
    input logic        tlb_en,
    input tlb_result_t tlb_res,
    input logic        exc_tlbr,
    input logic        exc_tlbi,
    input logic        exc_tlbm
);

    bus_quiet_on_exc: assert property (@(posedge clk) disable iff (rst)
        exc_flag |-> !bus_en)
        else $error("bus_en high while exc_flag is set");

    // pending search must hold the pipeline
    stall_while_search: assert property (@(posedge clk) disable iff (rst)
        tlb_en && !tlb_res.rdy |-> stallreq)
        else $error("TLB search pending without stallreq");

    one_exception: assert property (@(posedge clk) disable iff (rst)
        $onehot0({exc_tlbr, exc_tlbi, exc_tlbm}))
        else $error("more than one TLB exception raised");

    rdy_low_after_rst: assert property (@(posedge clk)
        rst |=> !tlb_res.rdy)
        else $error("TLB ready high right after reset");

endmodule

bind mmu_top mmu_top_chk mmu_top_chk_i (
    .clk      (clk),
    .rst      (rst),
    .exc_flag (exc_flag),
    .bus_en   (bus_en),
    .stallreq (stallreq),
    .tlb_en   (tlb_en),
    .tlb_res  (tlb_res),
    .exc_tlbr (exc_tlbr),
    .exc_tlbi (exc_tlbi),
    .exc_tlbm (exc_tlbm)
);

// ==== tb/mmu_top_tb.sv ====
`timescale 1ns/1ns

module mmu_top_tb import mmu_pkg::*; ();

    localparam logic [3:0] LD = WR_DISABLE;
    localparam logic [3:0] ST = 4'hf;
    localparam logic       Y  = 1'b1;
    localparam logic       N  = 1'b0;
    localparam logic [1:0] K_WR  = 2'd0;     // cp0 write
    localparam logic [1:0] K_WI  = 2'd1;     // tlbwi pulse
    localparam logic [1:0] K_RD  = 2'd2;     // cp0 readback
    localparam logic [1:0] K_ACC = 2'd3;     // load or store

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] addr;                  // vaddr or cp0 number
        logic [31:0] data;                  // write data or expected readback
        logic [3:0]  wen;
        logic        exc;
        logic        stall;                 // one-cycle bus stall
        logic [31:0] paddr;
        logic        cached;
        logic        bus_on;
        logic [2:0]  flags;                 // tlbr, tlbi, tlbm
        logic        stalls;                // stallreq seen at all
    } row_t;

    logic        clk, rst, en, exc_flag, bus_en, bus_streq, bus_cached, stallreq;
    logic        exc_tlbr, exc_tlbi, exc_tlbm, cp0_we, tlbwi;
    logic [3:0]  wen, bus_wen;
    logic [4:0]  cp0_addr;
    logic [31:0] vaddr, wdata, rdata, bus_paddr, bus_wdata, bus_rdata, cp0_wdata, cp0_rdata;

    row_t  rows[$];
    string names[$];
    string cur_name;
    logic  row_bad;
    int    cycles = 0;
    int    limit = 0;
    int    n_pass = 0;
    int    n_fail = 0;

    mmu_top #(.TLB_ENTRIES(TLB_ENTRIES)) mmu_top_i (.*);

    function automatic logic [31:0] mem_word(logic [31:0] a);
        return {a[15:0], ~a[31:16]};
    endfunction

    // PFN at 25:6, C at 5:3, D at 2, V at 1
    function automatic logic [31:0] lo_word(logic [19:0] pfn, logic c, logic d, logic v);
        return {6'd0, pfn, 2'b00, c, d, v, 1'b0};
    endfunction

    assign bus_rdata = mem_word(bus_paddr);  // bus stub

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("run stopped at cycle limit %0d", limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic put(string name, logic [1:0] kind, logic [31:0] addr, logic [31:0] data,
                       logic [3:0] w, logic exc, logic stall, logic [31:0] pa,
                       logic cached, logic on, logic [2:0] flags, logic stalls);
        rows.push_back({kind, addr, data, w, exc, stall, pa, cached, on, flags, stalls});
        names.push_back(name);
    endtask

    task automatic reg_wr(string name, logic [4:0] r, logic [31:0] d);
        put(name, K_WR, {27'd0, r}, d, LD, N, N, 32'h0, N, N, 3'b000, N);
    endtask

    task automatic reg_rd(string name, logic [4:0] r, logic [31:0] d);
        put(name, K_RD, {27'd0, r}, d, LD, N, N, 32'h0, N, N, 3'b000, N);
    endtask

    task automatic wi_pulse(string name);
        put(name, K_WI, 32'h0, 32'h0, LD, N, N, 32'h0, N, N, 3'b000, N);
    endtask

    task automatic access(string name, logic [31:0] va, logic [3:0] w, logic exc,
                          logic stall, logic [31:0] pa, logic cached, logic on,
                          logic [2:0] flags, logic stalls);
        put(name, K_ACC, va, 32'h0, w, exc, stall, pa, cached, on, flags, stalls);
    endtask

    task automatic build_table();
        access("reset_refill", 32'h0040_0000, LD, N, N, 32'h0, N, Y, 3'b100, Y);
        access("kseg0_unc",    32'h8000_1000, LD, N, N, 32'h0000_1000, N, Y, 3'b000, N);
        access("kseg1_unc",    32'ha000_2000, ST, N, N, 32'h0000_2000, N, Y, 3'b000, N);
        reg_wr("config_k0", CP0_CONFIG, 32'h0000_0001);
        access("kseg0_cached", 32'h8000_3000, LD, N, N, 32'h0000_3000, Y, Y, 3'b000, N);
        access("kseg1_k0",     32'ha000_4000, LD, N, N, 32'h0000_4000, N, Y, 3'b000, N);
        // entry 1, kuseg page to a cached frame
        reg_wr("hi_a", CP0_ENTRYHI, 32'h0040_0000);
        reg_wr("lo_a", CP0_ENTRYLO, lo_word(20'h12345, Y, Y, Y));
        reg_wr("index_a", CP0_INDEX, 32'd1);
        wi_pulse("wi_a");
        access("hit_a",        32'h0040_0000, LD, N, N, 32'h1234_5000, Y, Y, 3'b000, Y);
        // entry 5, kseg2 page to an uncached frame
        reg_wr("hi_b", CP0_ENTRYHI, 32'hc000_5000);
        reg_wr("lo_b", CP0_ENTRYLO, lo_word(20'h00abc, N, Y, Y));
        reg_wr("index_b", CP0_INDEX, 32'd5);
        wi_pulse("wi_b");
        access("hit_b",        32'hc000_5000, ST, N, N, 32'h00ab_c000, N, Y, 3'b000, Y);
        reg_wr("hi_inv", CP0_ENTRYHI, 32'h0050_0000);
        reg_wr("lo_inv", CP0_ENTRYLO, lo_word(20'h00777, Y, Y, N));
        reg_wr("index_inv", CP0_INDEX, 32'd2);
        wi_pulse("wi_inv");
        access("invalid",      32'h0050_0000, LD, N, N, 32'h0, N, Y, 3'b010, Y);
        // entry 6 read only, stray bits written to every register
        reg_wr("hi_ro", CP0_ENTRYHI, 32'h0060_0abc);
        reg_wr("lo_ro", CP0_ENTRYLO, lo_word(20'h00888, Y, N, Y) | 32'hfc00_0031);
        reg_wr("index_ro", CP0_INDEX, 32'hffff_fff6);
        wi_pulse("wi_ro");
        access("store_ro",     32'h0060_0000, ST, N, N, 32'h0, N, Y, 3'b001, Y);
        access("load_ro",      32'h0060_0000, LD, N, N, 32'h0088_8000, Y, Y, 3'b000, Y);
        reg_rd("rd_index", CP0_INDEX, 32'h0000_0006);
        reg_rd("rd_hi", CP0_ENTRYHI, 32'h0060_0000);
        reg_rd("rd_lo", CP0_ENTRYLO, lo_word(20'h00888, Y, N, Y));
        reg_rd("rd_config", CP0_CONFIG, 32'h0000_0001);
        reg_wr("status_erl", CP0_STATUS, 32'hffff_ffff);
        reg_rd("rd_status", CP0_STATUS, 32'h0000_0004);
        access("erl_kseg2",    32'hc000_6000, LD, N, N, 32'h0000_6000, N, Y, 3'b000, N);
        access("erl_kuseg",    32'h0040_0000, LD, N, N, 32'h0040_0000, N, Y, 3'b000, N);
        reg_wr("status_clr", CP0_STATUS, 32'h0);
        access("exc_flag",     32'ha000_7000, LD, Y, N, 32'h0, N, N, 3'b000, N);
        access("bus_stall",    32'ha000_8000, ST, N, Y, 32'h0000_8000, N, Y, 3'b000, Y);
        reg_rd("rd_unknown", 5'd7, 32'h0);
    endtask

    task automatic idle();
        en        = 1'b0;
        wen       = LD;
        vaddr     = 32'h0;
        wdata     = 32'h0;
        exc_flag  = 1'b0;
        bus_streq = 1'b0;
        cp0_we    = 1'b0;
        cp0_addr  = 5'd0;
        cp0_wdata = 32'h0;
        tlbwi     = 1'b0;
    endtask

    task automatic expect_val(string what, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s expected %h actual %h", cur_name, what, exp, act);
            row_bad = 1'b1;
        end
    endtask

    task automatic apply(row_t r);
        logic [11:0] off;
        logic [31:0] exp_pa;
        logic        saw;
        off    = 12'($urandom);             // random offset within the page
        exp_pa = {r.paddr[31:12], off};
        saw    = 1'b0;
        @(negedge clk);
        if (r.kind == K_WR) begin
            cp0_we    = 1'b1;
            cp0_addr  = r.addr[4:0];
            cp0_wdata = r.data;
        end else if (r.kind == K_WI) begin
            tlbwi = 1'b1;
        end else if (r.kind == K_RD) begin
            cp0_addr = r.addr[4:0];
        end else begin
            en        = 1'b1;
            wen       = r.wen;
            vaddr     = {r.addr[31:12], off};
            wdata     = $urandom;
            exc_flag  = r.exc;
            bus_streq = r.stall;
        end
        @(negedge clk);
        while (stallreq) begin
            saw       = 1'b1;
            bus_streq = 1'b0;               // bus stall lasts one cycle
            @(negedge clk);
        end
        if (r.kind == K_RD) begin
            expect_val("cp0_rdata", r.data, cp0_rdata);
        end else if (r.kind == K_ACC) begin
            expect_val("stalled", 32'(r.stalls), 32'(saw));
            expect_val("bus_en", 32'(r.bus_on), 32'(bus_en));
            expect_val("bus_wen", 32'(r.wen), 32'(bus_wen));
            expect_val("exc_flags", 32'(r.flags), 32'({exc_tlbr, exc_tlbi, exc_tlbm}));
            if (r.bus_on && r.flags == 3'b000) begin
                expect_val("bus_paddr", exp_pa, bus_paddr);
                expect_val("bus_cached", 32'(r.cached), 32'(bus_cached));
                expect_val("rdata", mem_word(exp_pa), rdata);
                expect_val("bus_wdata", wdata, bus_wdata);
            end
        end
        idle();
    endtask

    initial begin
        void'($urandom(32'hc72a));
        idle();
        rst = 1'b1;
        build_table();
        limit = rows.size() * (TLB_ENTRIES + 4) + 5 + 2;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            cur_name = names[i];
            row_bad  = 1'b0;
            apply(rows[i]);
            if (row_bad) begin
                n_fail++;
                $display("fail %s", cur_name);
            end else begin
                n_pass++;
                $display("pass %s", cur_name);
            end
        end
        $display("%0d rows passed, %0d rows failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
verilog/mmu_pkg.sv
verilog/cp0_mmu_regs.sv
verilog/tlb_lookup.sv
verilog/mmu_translate.sv
verilog/mmu_top.sv
tb/mmu_top_chk.sv
tb/mmu_top_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mmu_top_tb
FILELIST  = list.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJDIR)
